// File: hdl/core_pkg.sv
package core_pkg;

    localparam int IMEM_AW = 6; // 64 instruction words

    // Opcode in bits 31:26, unlisted values execute as no-ops
    typedef enum logic [5:0] {
        ADDI  = 6'h01,
        SUBI  = 6'h02,
        LOADI = 6'h03,
        HALT  = 6'h3F
    } opcode_e;

    // Core state as seen by the debug dump
    typedef struct packed {
        logic [31:0] pc;      // Next instruction address
        logic [31:0] acc;
        logic [31:0] retired; // HALT included
    } snapshot_t;

    // One port request into instruction memory
    typedef struct packed {
        logic               valid;
        logic               write;
        logic [IMEM_AW-1:0] addr;
        logic [31:0]        data;
    } imem_req_t;

endpackage

// File: hdl/debug_pkg.sv
package debug_pkg;

    // Command bytes from the host
    typedef enum logic [7:0] {
        CMD_START      = 8'h01,
        CMD_CONTINUOUS = 8'h02,
        CMD_STEP_MODE  = 8'h03,
        CMD_REPROGRAM  = 8'h05,
        CMD_STEP       = 8'h06
    } cmd_e;

    typedef enum logic [2:0] {
        IDLE,         // Waiting for START
        PROGRAMMING,
        WAITING,      // Core held until a mode command
        STEP_BY_STEP,
        CONTINUOUS,
        SENDING       // 12 byte state dump
    } dbg_state_e;

endpackage

// File: hdl/uart_rx.sv
`timescale 1ns/100ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_done
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e   state;
    logic [1:0]  rx_sync;   // Two flop synchronizer
    logic [CW-1:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shreg;

    assign rx_byte = shreg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RX_IDLE;
            rx_sync <= 2'b11;
            cnt     <= '0;
            bit_idx <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_done <= 1'b0;
            cnt     <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync[1]) state <= RX_START;
                end
                RX_START: if (cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync[1] ? RX_IDLE : RX_DATA; // Glitch check at mid-bit
                end
                RX_DATA: if (cnt == CW'(CLKS_PER_BIT - 1)) begin
                    cnt     <= '0;
                    shreg   <= {rx_sync[1], shreg[7:1]}; // LSB first
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                default: if (cnt == CW'(CLKS_PER_BIT - 1)) begin
                    rx_done <= rx_sync[1];
                    state   <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy,
    output logic       tx_done
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    logic [9:0]    frame;   // Stop, data, start
    logic [3:0]    bit_idx;
    logic [CW-1:0] cnt;

    assign tx = tx_busy ? frame[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_busy <= 1'b0;
            tx_done <= 1'b0;
            bit_idx <= '0;
            cnt     <= '0;
        end else begin
            tx_done <= 1'b0;
            if (!tx_busy) begin
                if (tx_start) begin
                    frame   <= {1'b1, tx_byte, 1'b0};
                    tx_busy <= 1'b1;
                    bit_idx <= '0;
                    cnt     <= '0;
                end
            end else if (cnt == CW'(CLKS_PER_BIT - 1)) begin
                cnt   <= '0;
                frame <= {1'b1, frame[9:1]};
                if (bit_idx == 4'd9) begin // End of stop bit
                    tx_busy <= 1'b0;
                    tx_done <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/imem_arbiter.sv
`timescale 1ns/100ps

module imem_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::imem_req_t load_req,
    input  core_pkg::imem_req_t fetch_req,
    output logic                fetch_gnt,
    output logic [31:0]         fetch_data
);

    localparam int DEPTH = 2 ** core_pkg::IMEM_AW;

    logic [31:0] mem [DEPTH];
    logic        wr_gnt;

    ////////////////////////////////////////////////////////////
    // Loader write wins over fetch
    ////////////////////////////////////////////////////////////

    assign wr_gnt    = load_req.valid && load_req.write;
    assign fetch_gnt = fetch_req.valid && !fetch_req.write && !wr_gnt;

    always_ff @(posedge clk) begin
        if (wr_gnt) begin
            mem[load_req.addr] <= load_req.data; // Done in grant cycle
        end
    end

    // Read data lands one cycle after the grant
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_data <= '0;
        end else if (fetch_gnt) begin
            fetch_data <= mem[fetch_req.addr];
        end
    end

endmodule

// File: hdl/accum_core.sv
`timescale 1ns/100ps

module accum_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                core_hold,
    input  logic                run,
    input  logic                step,
    output core_pkg::imem_req_t fetch_req,
    input  logic                fetch_gnt,
    input  logic [31:0]         fetch_data,
    output core_pkg::snapshot_t snap,
    output logic                retire,
    output logic                halted
);

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_DATA, S_EXEC, S_HALT} core_state_e;

    core_state_e        state;
    logic [31:0]        pc;
    logic [31:0]        acc;
    logic [31:0]        retired;
    logic [31:0]        ir;
    logic [31:0]        imm;
    logic               step_pend; // Step seen but not yet started
    core_pkg::opcode_e  op;

    assign op  = core_pkg::opcode_e'(ir[31:26]);
    assign imm = {16'h0000, ir[15:0]};

    always_comb begin
        fetch_req.valid = (state == S_FETCH);
        fetch_req.write = 1'b0;
        fetch_req.addr  = pc[core_pkg::IMEM_AW-1:0];
        fetch_req.data  = '0;
    end

    assign snap = '{pc: pc, acc: acc, retired: retired};

    ////////////////////////////////////////////////////////////
    // Fetch, data, execute
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || core_hold) begin
            state     <= S_IDLE;
            pc        <= '0;
            acc       <= '0;
            retired   <= '0;
            step_pend <= 1'b0;
            retire    <= 1'b0;
            halted    <= 1'b0;
        end else begin
            retire <= 1'b0;
            case (state)
                S_IDLE: if (run || step_pend) begin
                    state     <= S_FETCH;
                    step_pend <= 1'b0;
                end
                S_FETCH: if (fetch_gnt) state <= S_DATA;
                S_DATA: begin
                    ir    <= fetch_data;
                    state <= S_EXEC;
                end
                S_EXEC: begin
                    retire  <= 1'b1;
                    retired <= retired + 32'd1;
                    pc      <= pc + 32'd1;
                    state   <= run ? S_FETCH : S_IDLE;
                    case (op)
                        core_pkg::LOADI: acc <= imm;
                        core_pkg::ADDI:  acc <= acc + imm;
                        core_pkg::SUBI:  acc <= acc - imm;
                        core_pkg::HALT: begin
                            pc     <= pc; // Stays on the HALT
                            halted <= 1'b1;
                            state  <= S_HALT;
                        end
                        default: ;
                    endcase
                end
                default: ; // S_HALT until core_hold
            endcase
            if (step) step_pend <= 1'b1;
        end
    end

endmodule

// File: hdl/debug_unit.sv
`timescale 1ns/100ps

module debug_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic [7:0]          rx_byte,
    input  logic                rx_done,
    output logic [7:0]          tx_byte,
    output logic                tx_start,
    input  logic                tx_done,
    output core_pkg::imem_req_t load_req,
    output logic                core_hold,
    output logic                run,
    output logic                step,
    input  core_pkg::snapshot_t snap,
    input  logic                retire,
    input  logic                halted
);

    debug_pkg::dbg_state_e         state;
    debug_pkg::cmd_e               cmd;
    logic [31:0]                   word;      // Instruction being assembled
    logic [1:0]                    byte_cnt;
    logic [core_pkg::IMEM_AW-1:0]  wr_addr;
    logic                          load_valid;
    core_pkg::snapshot_t           snap_q;
    logic [3:0]                    idx;       // Dump byte 0 to 11
    logic [31:0]                   dump_word;
    logic                          tx_wait;   // Byte in flight
    logic                          step_wait;

    assign cmd = debug_pkg::cmd_e'(rx_byte);

    always_comb begin
        load_req.valid = load_valid;
        load_req.write = 1'b1;
        load_req.addr  = wr_addr;
        load_req.data  = word;
    end

    // pc, acc, retired in that order
    always_comb begin
        case (idx[3:2])
            2'd0:    dump_word = snap_q.pc;
            2'd1:    dump_word = snap_q.acc;
            default: dump_word = snap_q.retired;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= debug_pkg::WAITING;
            core_hold  <= 1'b1;
            run        <= 1'b0;
            step       <= 1'b0;
            tx_start   <= 1'b0;
            load_valid <= 1'b0;
            byte_cnt   <= '0;
            wr_addr    <= '0;
            idx        <= '0;
            tx_wait    <= 1'b0;
            step_wait  <= 1'b0;
        end else begin
            tx_start   <= 1'b0;
            step       <= 1'b0;
            load_valid <= 1'b0;
            case (state)
                debug_pkg::IDLE: begin
                    if (rx_done && cmd == debug_pkg::CMD_START) begin
                        state    <= debug_pkg::PROGRAMMING;
                        byte_cnt <= '0;
                        wr_addr  <= '0;
                    end
                end
                debug_pkg::PROGRAMMING: begin
                    if (rx_done) begin
                        word       <= {rx_byte, word[31:8]}; // LSB first
                        byte_cnt   <= byte_cnt + 1'b1;
                        load_valid <= (byte_cnt == 2'd3);
                    end
                    if (load_valid) begin
                        wr_addr <= wr_addr + 1'b1;
                        if (&word[31:26]) state <= debug_pkg::WAITING; // HALT ends load
                    end
                end
                debug_pkg::WAITING: begin
                    if (rx_done) begin
                        case (cmd)
                            debug_pkg::CMD_REPROGRAM: state <= debug_pkg::IDLE;
                            debug_pkg::CMD_CONTINUOUS: begin
                                state     <= debug_pkg::CONTINUOUS;
                                core_hold <= 1'b0;
                                run       <= 1'b1;
                            end
                            debug_pkg::CMD_STEP_MODE: begin
                                state     <= debug_pkg::STEP_BY_STEP;
                                core_hold <= 1'b0;
                            end
                            default: ;
                        endcase
                    end
                end
                debug_pkg::CONTINUOUS: begin
                    if (retire && halted) begin
                        snap_q <= snap;
                        run    <= 1'b0;
                        idx    <= '0;
                        state  <= debug_pkg::SENDING;
                    end
                end
                debug_pkg::STEP_BY_STEP: begin
                    if (step_wait) begin
                        if (retire) begin
                            step_wait <= 1'b0;
                            snap_q    <= snap;
                            idx       <= '0;
                            state     <= debug_pkg::SENDING;
                        end
                    end else if (rx_done && cmd == debug_pkg::CMD_STEP) begin
                        step      <= 1'b1;
                        step_wait <= 1'b1;
                    end
                end
                default: begin // One dump byte per tx_done
                    if (!tx_wait) begin
                        tx_byte  <= dump_word[{idx[1:0], 3'b000} +: 8];
                        tx_start <= 1'b1;
                        tx_wait  <= 1'b1;
                    end else if (tx_done) begin
                        tx_wait <= 1'b0;
                        if (idx == 4'd11) begin
                            if (halted) begin
                                state     <= debug_pkg::WAITING;
                                core_hold <= 1'b1;
                            end else begin
                                state <= debug_pkg::STEP_BY_STEP;
                            end
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/debug_top.sv
`timescale 1ns/100ps

module debug_top #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx
);

    logic [7:0]          rx_byte;
    logic                rx_done;
    logic [7:0]          tx_byte;
    logic                tx_start;
    logic                tx_done;
    core_pkg::imem_req_t load_req;
    core_pkg::imem_req_t fetch_req;
    logic                fetch_gnt;
    logic [31:0]         fetch_data;
    logic                core_hold;
    logic                run;
    logic                step;
    core_pkg::snapshot_t snap;
    logic                retire;
    logic                halted;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx0 (
        .clk(clk), .reset(reset), .rx(rx), .rx_byte(rx_byte), .rx_done(rx_done)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx0 (
        .clk(clk), .reset(reset), .tx_byte(tx_byte), .tx_start(tx_start),
        .tx(tx), .tx_busy(), .tx_done(tx_done)
    );

    debug_unit dbg0 (
        .clk(clk), .reset(reset),
        .rx_byte(rx_byte), .rx_done(rx_done),
        .tx_byte(tx_byte), .tx_start(tx_start), .tx_done(tx_done),
        .load_req(load_req), .core_hold(core_hold), .run(run), .step(step),
        .snap(snap), .retire(retire), .halted(halted)
    );

    accum_core core0 (
        .clk(clk), .reset(reset),
        .core_hold(core_hold), .run(run), .step(step),
        .fetch_req(fetch_req), .fetch_gnt(fetch_gnt), .fetch_data(fetch_data),
        .snap(snap), .retire(retire), .halted(halted)
    );

    imem_arbiter arb0 (
        .clk(clk), .reset(reset),
        .load_req(load_req), .fetch_req(fetch_req),
        .fetch_gnt(fetch_gnt), .fetch_data(fetch_data)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: test/debug_sva.sv
`timescale 1ns/100ps

module debug_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  tx_start,
    input logic                  tx_done,
    input core_pkg::imem_req_t   load_req,
    input debug_pkg::dbg_state_e state,
    input logic                  core_hold,
    input logic                  run,
    input logic                  step
);

    logic in_flight; // Byte started but its tx_done not seen yet
    int   tx_errors = 0;
    int   load_errors = 0;
    int   hold_errors = 0;
    int   failures;

    assign failures = tx_errors + load_errors + hold_errors;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 1'b0;
        end else if (tx_start) begin
            in_flight <= 1'b1;
        end else if (tx_done) begin
            in_flight <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Protocol rules
    ////////////////////////////////////////////////////////////

    tx_backpressure: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !in_flight)
    else begin
        tx_errors = tx_errors + 1;
        $error("tx_start issued before tx_done of the previous byte");
    end

    load_in_programming: assert property (@(posedge clk) disable iff (reset)
        load_req.valid |-> state == debug_pkg::PROGRAMMING)
    else begin
        load_errors = load_errors + 1;
        $error("load request outside of PROGRAMMING");
    end

    no_run_while_held: assert property (@(posedge clk) disable iff (reset)
        (run || step) |-> !core_hold)
    else begin
        hold_errors = hold_errors + 1;
        $error("run or step active while core_hold is high");
    end

endmodule

bind debug_unit debug_sva sva0 (
    .clk(clk), .reset(reset), .tx_start(tx_start), .tx_done(tx_done),
    .load_req(load_req), .state(state), .core_hold(core_hold), .run(run), .step(step)
);

// File: test/debug_tb.sv
`timescale 1ns/100ps

module debug_tb;

    localparam int CLKS_PER_BIT = 8;
    localparam int BYTE_TIMEOUT = 4000; // Cycles to wait for a start bit

    logic        clk;
    logic        reset;
    logic        rx;
    logic        tx;
    logic [31:0] prog [64]; // Program model
    int          prog_len;
    int          seed;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(4)) clk0 (.clk(clk), .reset(reset));

    debug_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut0 (.clk(clk), .reset(reset), .rx(rx), .tx(tx));

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run stopped on a failed check");
    endtask

    function automatic logic [31:0] encode(input logic [5:0] op, input logic [15:0] imm);
        return {op, 10'h000, imm};
    endfunction

    // Runs up to n instructions of prog by the opcode rules
    function automatic void predict(input int n, output logic [31:0] pc,
                                    output logic [31:0] acc, output logic [31:0] ret);
        logic [5:0]  op;
        logic [31:0] imm;
        pc  = '0;
        acc = '0;
        ret = '0;
        for (int i = 0; i < n; i++) begin
            op  = prog[pc[5:0]][31:26];
            imm = {16'h0000, prog[pc[5:0]][15:0]};
            ret = ret + 32'd1;
            if (op == core_pkg::HALT) break;
            if (op == core_pkg::LOADI) acc = imm;
            else if (op == core_pkg::ADDI) acc = acc + imm;
            else if (op == core_pkg::SUBI) acc = acc - imm;
            pc = pc + 32'd1;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Serial stimulus and decoding
    ////////////////////////////////////////////////////////////

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            send_byte(w[8*i +: 8]); // LSB first
        end
    endtask

    task automatic load_program();
        send_byte(debug_pkg::CMD_REPROGRAM);
        send_byte(debug_pkg::CMD_START);
        for (int i = 0; i < prog_len; i++) begin
            send_word(prog[i]);
        end
    endtask

    task automatic receive_byte(input string label, output logic [7:0] b);
        int waited;
        waited = 0;
        b = '0;
        while (tx !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > BYTE_TIMEOUT) begin
                report_fail($sformatf("timeout: %s dump never arrived", label));
            end
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk); // Middle of start bit
        assert (tx === 1'b0)
            else report_fail($sformatf("error: tx start bit expected 0 got %h in %s", tx, label));
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (tx === 1'b1)
            else report_fail($sformatf("error: tx stop bit expected 1 got %h in %s", tx, label));
    endtask

    // Dump of 12 bytes with pc, acc and retired
    task automatic check_dump(input int n, input string label);
        logic [31:0] exp_pc;
        logic [31:0] exp_acc;
        logic [31:0] exp_ret;
        logic [31:0] got [3];
        logic [7:0]  b;
        predict(n, exp_pc, exp_acc, exp_ret);
        for (int k = 0; k < 12; k++) begin
            receive_byte(label, b);
            got[k / 4][8 * (k % 4) +: 8] = b;
        end
        assert (got[0] == exp_pc)
            else report_fail($sformatf("error: pc expected %h got %h in %s", exp_pc, got[0], label));
        assert (got[1] == exp_acc)
            else report_fail($sformatf("error: acc expected %h got %h in %s", exp_acc, got[1], label));
        assert (got[2] == exp_ret)
            else report_fail($sformatf("error: retired expected %h got %h in %s",
                                       exp_ret, got[2], label));
    endtask

    task automatic expect_quiet(input int cycles, input string label);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (tx === 1'b1)
                else report_fail($sformatf("error: tx expected 1 got %h %s", tx, label));
        end
    endtask

    // Bound protocol checker stops the run at its first failure
    always @(negedge clk) begin
        if (dut0.dbg0.sva0.failures != 0) begin
            report_fail("protocol assertion in the debug unit failed");
        end
    end

    initial begin
        int waited;
        rx       = 1'b1;
        seed     = 77659;
        waited   = 0;
        prog_len = 6;
        prog[0]  = encode(core_pkg::LOADI, 16'h1234);
        prog[1]  = encode(core_pkg::ADDI, 16'h0100);
        prog[2]  = encode(core_pkg::SUBI, 16'h0034);
        prog[3]  = encode(6'h00, 16'h5555);       // No-op
        prog[4]  = encode(core_pkg::ADDI, 16'hFFFF);
        prog[5]  = encode(core_pkg::HALT, 16'h0000);

        while (reset !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > 50) report_fail("reset never released");
        end

        expect_quiet(200, "after reset");

        load_program();
        send_byte(debug_pkg::CMD_CONTINUOUS);
        check_dump(64, "continuous run");

        send_byte(debug_pkg::CMD_STEP_MODE);
        for (int i = 1; i <= prog_len; i++) begin
            send_byte(debug_pkg::CMD_STEP);
            check_dump(i, $sformatf("step %0d", i));
        end

        // Second program with fresh immediates
        prog[0] = encode(core_pkg::LOADI, 16'($random(seed)));
        prog[1] = encode(core_pkg::SUBI, 16'($random(seed)));
        prog[2] = encode(core_pkg::ADDI, 16'($random(seed)));
        prog[3] = encode(6'h2A, 16'($random(seed)));
        prog[4] = encode(core_pkg::SUBI, 16'($random(seed)));
        prog[5] = encode(core_pkg::HALT, 16'h0000);
        load_program();
        send_byte(debug_pkg::CMD_CONTINUOUS);
        check_dump(64, "reprogrammed run");

        send_byte(8'h00);
        send_byte(8'hA5);
        send_byte(8'h04);
        expect_quiet(300, "after unknown commands");
        send_byte(debug_pkg::CMD_CONTINUOUS);
        check_dump(64, "run after unknown commands");

        if (dut0.dbg0.sva0.failures == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_fail("protocol assertions failed during the run");
        end
    end

endmodule

// File: list.f
hdl/core_pkg.sv
hdl/debug_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/imem_arbiter.sv
hdl/accum_core.sv
hdl/debug_unit.sv
hdl/debug_top.sv
test/tb_clock.sv
test/debug_sva.sv
test/debug_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module debug_tb -f list.f > build.log 2>&1 \
    && ./obj_dir/Vdebug_tb +verilator+error+limit+100 > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "^TB PASSED$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
